// ==== burstCounter.sv ====
/*
  Burst beat counter
  Tracks the beat offset inside a burst and flags the final beat
*/
`timescale 1ns/1ps

module burstCounter import macPkg::*; (
  input  logic            clk,
  input  logic            resetn,
  input  logic [lenW-1:0] lenIn,
  issueIf.counter         ctl
);

  logic [lenW-1:0] lenQ;
  logic [lenW-1:0] offset;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      lenQ   <= '0;
      offset <= '0;
    end else if (ctl.load) begin
      lenQ   <= lenIn;
      offset <= '0;
    end else if (ctl.advance) begin
      offset <= offset + 1'b1;
    end
  end

  assign ctl.beatOffset = offset;
  assign ctl.lastBeat   = (offset == lenQ);

endmodule

// ==== cmdIssue.sv ====
/*
  Command register
  Holds the granted request and forms bank, row and column per beat
*/
`timescale 1ns/1ps

module cmdIssue import macPkg::*; (
  input  logic             clk,
  input  logic             resetn,
  input  macReqT           grantItem,
  input  logic             grantWrite,
  issueIf.issue            ctl,
  output logic             cmdWrite,
  output logic [bankW-1:0] cmdBank,
  output logic [rowW-1:0]  cmdRow,
  output logic [colW-1:0]  cmdCol,
  output logic [tagW-1:0]  cmdTag,
  output logic [idW-1:0]   cmdId
);

  macReqT          itemQ;
  logic            writeQ;
  logic [colW-1:0] colQ;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      writeQ <= 1'b0;
    end else if (ctl.load) begin
      writeQ <= grantWrite;
    end
  end

  // Column of the beat in flight wraps at 256
  always_ff @(posedge clk) begin
    if (ctl.load) begin
      itemQ <= grantItem;
      colQ  <= grantItem.addr.f.col;
    end else if (ctl.advance) begin
      colQ <= itemQ.addr.f.col + colW'(ctl.beatOffset) + 1'b1;
    end
  end

  assign cmdWrite = writeQ;
  assign cmdBank  = itemQ.addr.f.bank;
  assign cmdRow   = itemQ.addr.f.row;
  assign cmdCol   = colQ;
  assign cmdTag   = itemQ.tag;
  assign cmdId    = itemQ.id;

endmodule

// ==== cmdSequencer.sv ====
/*
  Command sequencer
  Takes a grant, then runs one four-phase req/ack cycle per burst beat
*/
`timescale 1ns/1ps

module cmdSequencer import macPkg::*; (
  input  logic clk,
  input  logic resetn,
  input  logic grantValid,
  output logic take,
  output logic cmdReq,
  input  logic cmdAck,
  issueIf.seq  ctl
);

  logic [1:0] state;
  logic [1:0] nextState;

  always_comb begin
    nextState = state;
    case (state)
      seqIdle: begin
        if (grantValid) begin
          nextState = seqIssue;
        end
      end
      // First beat and follow-on beats both hold req until ack
      seqIssue, seqNext: begin
        if (cmdAck) begin
          nextState = seqWaitAckLow;
        end
      end
      seqWaitAckLow: begin
        if (!cmdAck) begin
          nextState = ctl.lastBeat ? seqIdle : seqNext;
        end
      end
      default: nextState = seqIdle;
    endcase
  end

  assign take        = (state == seqIdle) & grantValid;
  assign ctl.load    = take;
  // Offset steps on the same edge that raises req again
  assign ctl.advance = (state == seqWaitAckLow) & ~cmdAck & ~ctl.lastBeat;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state  <= seqIdle;
      cmdReq <= 1'b0;
    end else begin
      state  <= nextState;
      cmdReq <= (nextState == seqIssue) || (nextState == seqNext);
    end
  end

endmodule

// ==== issueIf.sv ====
/*
  Burst issue control bus
  Links the command sequencer, the beat counter and the command register
*/
`timescale 1ns/1ps

interface issueIf import macPkg::*; ();

  logic            load;        // New request granted
  logic            advance;     // Step to next beat
  logic [lenW-1:0] beatOffset;
  logic            lastBeat;

  modport seq     (output load, output advance, input lastBeat);
  modport counter (input load, input advance, output beatOffset, output lastBeat);
  modport issue   (input load, input advance, input beatOffset);

endinterface

// ==== macChecker.sv ====
/*
  Controller checker
  Models both request queues and compares every issued command burst
*/
`timescale 1ns/1ps

module macChecker import macPkg::*; (
  input  logic             clk,
  input  logic             resetn,
  input  logic             wrValid,
  input  logic [addrW-1:0] wrAddr,
  input  logic [tagW-1:0]  wrTag,
  input  logic [idW-1:0]   wrId,
  input  logic [lenW-1:0]  wrLen,
  input  logic             wrReady,
  input  logic             rdValid,
  input  logic [addrW-1:0] rdAddr,
  input  logic [tagW-1:0]  rdTag,
  input  logic [idW-1:0]   rdId,
  input  logic [lenW-1:0]  rdLen,
  input  logic             rdReady,
  input  logic             cmdReq,
  input  logic             cmdAck,
  input  logic             cmdWrite,
  input  logic [bankW-1:0] cmdBank,
  input  logic [rowW-1:0]  cmdRow,
  input  logic [colW-1:0]  cmdCol,
  input  logic [tagW-1:0]  cmdTag,
  input  logic [idW-1:0]   cmdId,
  output int               acceptCount,
  output logic             idle,
  output int               errorCount
);

  macReqT wrModel[$];
  macReqT rdModel[$];
  macReqT cur;           // Request of the burst in flight
  int     cmdErrors = 0;
  int     arbErrors = 0;
  int     readyErrors = 0;
  int     resetErrors = 0;
  int     beat = 0;
  logic   burstActive = 1'b0;
  logic   lastWrite = 1'b0;   // Read before the first burst
  logic   bothWaiting = 1'b0;
  logic   reqPrev = 1'b0;
  logic   ackPrev = 1'b0;

  initial begin
    acceptCount = 0;
    idle = 1'b1;
  end

  assign errorCount = cmdErrors + arbErrors + readyErrors + resetErrors;

  task automatic checkReady(input logic ready, input int held, input string chan);
    if (ready && held > queueDepth) begin
      readyErrors++;
      $display("FAILED at %0t: %s ready high with %0d requests held", $time, chan, held);
    end else if (!ready && held < queueDepth) begin
      readyErrors++;
      $display("FAILED at %0t: %s ready low with %0d requests held", $time, chan, held);
    end
  endtask

  // Row is address bits 29:19, bank bits 9:8, column bits 7:0
  task automatic checkBeat();
    logic [colW-1:0]  expCol;
    logic [bankW-1:0] expBank;
    logic [rowW-1:0]  expRow;
    expCol  = cur.addr.raw[7:0] + colW'(beat);
    expBank = cur.addr.raw[9:8];
    expRow  = cur.addr.raw[29:19];
    if (cmdTag !== cur.tag || cmdId !== cur.id || cmdBank !== expBank ||
        cmdRow !== expRow || cmdCol !== expCol || cmdWrite !== lastWrite) begin
      cmdErrors++;
      $display("FAILED at %0t: beat %0d got wr %0b tag %0h id %0h bank %0h row %0h col %0h",
               $time, beat, cmdWrite, cmdTag, cmdId, cmdBank, cmdRow, cmdCol);
      $display("  expected wr %0b tag %0h id %0h bank %0h row %0h col %0h",
               lastWrite, cur.tag, cur.id, expBank, expRow, expCol);
    end
  endtask

  task automatic startBurst();
    if ((cmdWrite && wrModel.size() == 0) || (!cmdWrite && rdModel.size() == 0)) begin
      cmdErrors++;
      $display("Command issued with no pending %s request at %0t",
               cmdWrite ? "write" : "read", $time);
    end else begin
      if (bothWaiting && cmdWrite == lastWrite) begin
        arbErrors++;
        $display("FAILED at %0t: round-robin broken, burst repeats direction %s",
                 $time, cmdWrite ? "write" : "read");
      end
      cur = cmdWrite ? wrModel.pop_front() : rdModel.pop_front();
      lastWrite = cmdWrite;
      burstActive = 1'b1;
      beat = 0;
      checkBeat();
    end
  endtask

  always @(posedge clk) begin : watch
    macReqT item;
    if (!resetn) begin
      if (cmdReq || !wrReady || !rdReady) begin
        resetErrors++;
        $display("FAILED at %0t: outputs not at reset values during reset", $time);
      end
    end else begin
      checkReady(wrReady, wrModel.size(), "write");
      checkReady(rdReady, rdModel.size(), "read");
      if (cmdReq && !reqPrev) begin
        if (!burstActive) begin
          startBurst();
        end else if (beat >= int'(cur.len)) begin
          cmdErrors++;
          $display("FAILED at %0t: extra beat beyond burst length %0d", $time, cur.len + 1);
        end else begin
          beat++;
          checkBeat();
        end
      end
      // Burst ends when the final ack falls
      if (ackPrev && !cmdAck && burstActive && beat == int'(cur.len)) begin
        burstActive = 1'b0;
      end
      // Queues the arbiter sees when it takes the next grant
      if (!burstActive) begin
        bothWaiting = (wrModel.size() > 0) && (rdModel.size() > 0);
      end
      if (wrValid && wrReady) begin
        item.addr.raw = wrAddr;
        item.tag = wrTag;
        item.id = wrId;
        item.len = wrLen;
        wrModel.push_back(item);
        acceptCount++;
      end
      if (rdValid && rdReady) begin
        item.addr.raw = rdAddr;
        item.tag = rdTag;
        item.id = rdId;
        item.len = rdLen;
        rdModel.push_back(item);
        acceptCount++;
      end
    end
    reqPrev = cmdReq;
    ackPrev = cmdAck;
    idle = !burstActive && wrModel.size() == 0 && rdModel.size() == 0;
  end

  task automatic printSummary();
    $display("Errors: command %0d, arbitration %0d, ready %0d, reset %0d; left %0d wr %0d rd",
             cmdErrors, arbErrors, readyErrors, resetErrors, wrModel.size(), rdModel.size());
  endtask

endmodule

// ==== macPkg.sv ====
/*
  Memory access controller package
  Widths, queue depth, sequencer state codes and the request word types
*/
package macPkg;

  localparam int addrW = 32;
  localparam int tagW  = 4;
  localparam int idW   = 3;
  localparam int lenW  = 2;   // Beats = len + 1

  localparam int rowW  = 11;
  localparam int bankW = 2;
  localparam int colW  = 8;

  localparam int queueDepth = 8;

  // Command sequencer states
  localparam logic [1:0] seqIdle       = 2'd0;
  localparam logic [1:0] seqIssue      = 2'd1;
  localparam logic [1:0] seqWaitAckLow = 2'd2;
  localparam logic [1:0] seqNext       = 2'd3;

  // One address seen as the raw master word or as SDRAM fields
  typedef union packed {
    logic [addrW-1:0] raw;
    struct packed {
      logic [1:0]      rsvdHi;
      logic [rowW-1:0] row;    // Bits 29:19
      logic [8:0]      rsvdMid;
      logic [bankW-1:0] bank;  // Bits 9:8
      logic [colW-1:0] col;    // Bits 7:0
    } f;
  } macAddrU;

  // Queue entry of 41 bits
  typedef struct packed {
    macAddrU         addr;
    logic [tagW-1:0] tag;
    logic [idW-1:0]  id;
    logic [lenW-1:0] len;
  } macReqT;

endpackage

// ==== memAccessCtrl.sv ====
/*
  Memory access controller request front end
  Queues write and read requests, arbitrates and issues column command bursts
*/
`timescale 1ns/1ps

module memAccessCtrl import macPkg::*; (
  input  logic             clk,
  input  logic             resetn,
  // Write request channel
  input  logic             wrValid,
  input  logic [addrW-1:0] wrAddr,
  input  logic [tagW-1:0]  wrTag,
  input  logic [idW-1:0]   wrId,
  input  logic [lenW-1:0]  wrLen,
  output logic             wrReady,
  // Read request channel
  input  logic             rdValid,
  input  logic [addrW-1:0] rdAddr,
  input  logic [tagW-1:0]  rdTag,
  input  logic [idW-1:0]   rdId,
  input  logic [lenW-1:0]  rdLen,
  output logic             rdReady,
  // Four-phase command channel
  output logic             cmdReq,
  input  logic             cmdAck,
  output logic             cmdWrite,
  output logic [bankW-1:0] cmdBank,
  output logic [rowW-1:0]  cmdRow,
  output logic [colW-1:0]  cmdCol,
  output logic [tagW-1:0]  cmdTag,
  output logic [idW-1:0]   cmdId
);

  macReqT wrItem;
  macReqT rdItem;
  macReqT wrHead;
  macReqT rdHead;
  macReqT grantItem;
  logic   wrFull;
  logic   rdFull;
  logic   wrEmpty;
  logic   rdEmpty;
  logic   wrPop;
  logic   rdPop;
  logic   grantValid;
  logic   grantWrite;
  logic   take;

  issueIf ctlBus ();

  assign wrItem  = {wrAddr, wrTag, wrId, wrLen};
  assign rdItem  = {rdAddr, rdTag, rdId, rdLen};
  assign wrReady = ~wrFull;
  assign rdReady = ~rdFull;

  reqQueue #(.depth(queueDepth)) wrQueue (
    .clk(clk), .resetn(resetn),
    .push(wrValid & wrReady), .pushItem(wrItem), .full(wrFull),
    .pop(wrPop), .headItem(wrHead), .empty(wrEmpty)
  );

  reqQueue #(.depth(queueDepth)) rdQueue (
    .clk(clk), .resetn(resetn),
    .push(rdValid & rdReady), .pushItem(rdItem), .full(rdFull),
    .pop(rdPop), .headItem(rdHead), .empty(rdEmpty)
  );

  rrArbiter arbiter (
    .clk(clk), .resetn(resetn),
    .wrEmpty(wrEmpty), .rdEmpty(rdEmpty), .wrHead(wrHead), .rdHead(rdHead),
    .take(take), .wrPop(wrPop), .rdPop(rdPop),
    .grantValid(grantValid), .grantWrite(grantWrite), .grantItem(grantItem)
  );

  cmdSequencer sequencer (
    .clk(clk), .resetn(resetn), .grantValid(grantValid), .take(take),
    .cmdReq(cmdReq), .cmdAck(cmdAck), .ctl(ctlBus.seq)
  );

  burstCounter beatCounter (
    .clk(clk), .resetn(resetn), .lenIn(grantItem.len), .ctl(ctlBus.counter)
  );

  cmdIssue issueRegs (
    .clk(clk), .resetn(resetn), .grantItem(grantItem), .grantWrite(grantWrite),
    .ctl(ctlBus.issue), .cmdWrite(cmdWrite), .cmdBank(cmdBank), .cmdRow(cmdRow),
    .cmdCol(cmdCol), .cmdTag(cmdTag), .cmdId(cmdId)
  );

endmodule

// ==== memAccessCtrl_sva.sv ====
/*
  Command handshake assertions
  Bound into the controller top level to watch the four-phase req/ack rules
*/
`timescale 1ns/1ps

module memAccessCtrlSva import macPkg::*; (
  input logic             clk,
  input logic             resetn,
  input logic             cmdReq,
  input logic             cmdAck,
  input logic             cmdWrite,
  input logic [bankW-1:0] cmdBank,
  input logic [rowW-1:0]  cmdRow,
  input logic [colW-1:0]  cmdCol,
  input logic [tagW-1:0]  cmdTag,
  input logic [idW-1:0]   cmdId
);

  logic [1+bankW+rowW+colW+tagW+idW-1:0] fields;

  assign fields = {cmdWrite, cmdBank, cmdRow, cmdCol, cmdTag, cmdId};

  reqFallsAfterAck: assert property (@(posedge clk) disable iff (!resetn)
    $fell(cmdReq) |-> $past(cmdAck))
    else $error("cmdReq dropped before cmdAck was seen high");

  reqRisesAfterAckLow: assert property (@(posedge clk) disable iff (!resetn)
    $rose(cmdReq) |-> !$past(cmdAck))
    else $error("cmdReq raised while cmdAck was still high");

  // Fields hold from req rise until ack falls
  fieldsStable: assert property (@(posedge clk) disable iff (!resetn)
    (cmdReq || cmdAck) && $past(cmdReq || cmdAck) |-> $stable(fields))
    else $error("command fields changed during a handshake");

endmodule

bind memAccessCtrl memAccessCtrlSva handshakeSva (
  .clk(clk), .resetn(resetn), .cmdReq(cmdReq), .cmdAck(cmdAck),
  .cmdWrite(cmdWrite), .cmdBank(cmdBank), .cmdRow(cmdRow), .cmdCol(cmdCol),
  .cmdTag(cmdTag), .cmdId(cmdId)
);

// ==== reqQueue.sv ====
/*
  Request queue
  First-word-fall-through circular FIFO holding one request per entry
*/
`timescale 1ns/1ps

module reqQueue import macPkg::*; #(
  parameter int depth = queueDepth
) (
  input  logic   clk,
  input  logic   resetn,
  input  logic   push,
  input  macReqT pushItem,
  output logic   full,
  input  logic   pop,
  output macReqT headItem,
  output logic   empty
);

  macReqT mem [depth];

  logic [$clog2(depth)-1:0]   wrPtr;
  logic [$clog2(depth)-1:0]   rdPtr;
  logic [$clog2(depth+1)-1:0] count;
  logic                       pushEn;
  logic                       popEn;

  assign pushEn = push & ~full;
  assign popEn  = pop & ~empty;

  always_ff @(posedge clk) begin
    if (pushEn) begin
      mem[wrPtr] <= pushItem;
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (pushEn) begin
        wrPtr <= (int'(wrPtr) == depth - 1) ? '0 : wrPtr + 1'b1;
      end
      if (popEn) begin
        rdPtr <= (int'(rdPtr) == depth - 1) ? '0 : rdPtr + 1'b1;
      end
      if (pushEn && !popEn) begin
        count <= count + 1'b1;
      end else if (popEn && !pushEn) begin
        count <= count - 1'b1;
      end
    end
  end

  assign headItem = mem[rdPtr];   // Visible without a pop
  assign full     = (int'(count) == depth);
  assign empty    = (count == '0);

endmodule

// ==== rrArbiter.sv ====
/*
  Round-robin arbiter
  Picks the write or read queue head and pops the winner on take
*/
`timescale 1ns/1ps

module rrArbiter import macPkg::*; (
  input  logic   clk,
  input  logic   resetn,
  input  logic   wrEmpty,
  input  logic   rdEmpty,
  input  macReqT wrHead,
  input  macReqT rdHead,
  input  logic   take,
  output logic   wrPop,
  output logic   rdPop,
  output logic   grantValid,
  output logic   grantWrite,
  output macReqT grantItem
);

  logic lastWrite;   // Direction granted last time

  always_comb begin
    if (!wrEmpty && !rdEmpty) begin
      grantWrite = ~lastWrite;
    end else begin
      grantWrite = ~wrEmpty;
    end
  end

  assign grantValid = ~wrEmpty | ~rdEmpty;
  assign grantItem  = grantWrite ? wrHead : rdHead;
  assign wrPop      = take & grantValid & grantWrite;
  assign rdPop      = take & grantValid & ~grantWrite;

  // Starts as read so write wins the first tie
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      lastWrite <= 1'b0;
    end else if (take && grantValid) begin
      lastWrite <= grantWrite;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbMemAccessCtrl -f vlog.f -o simv
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
  exit 0
fi
exit 1

// ==== tbMemAccessCtrl.sv ====
/*
  Controller testbench
  Random request traffic, a random-delay ack responder and one long ack stall
*/
`timescale 1ns/1ps

module tbMemAccessCtrl import macPkg::*; ();

  localparam int totalReqs  = 200;
  localparam int cycleLimit = totalReqs * 4 * 12 + 1000;

  logic             clk = 1'b0;
  logic             resetn;
  logic             wrValid, rdValid, wrReady, rdReady;
  logic [addrW-1:0] wrAddr, rdAddr;
  logic [tagW-1:0]  wrTag, rdTag;
  logic [idW-1:0]   wrId, rdId;
  logic [lenW-1:0]  wrLen, rdLen;
  logic             cmdReq, cmdAck, cmdWrite;
  logic [bankW-1:0] cmdBank;
  logic [rowW-1:0]  cmdRow;
  logic [colW-1:0]  cmdCol;
  logic [tagW-1:0]  cmdTag;
  logic [idW-1:0]   cmdId;
  int               acceptCount, errorCount;
  logic             idle;

  logic [31:0] rngState;
  int          cycles = 0;
  int          ackDelay = 0;
  int          holdLeft = 0;
  logic        holdStarted = 1'b0;
  logic        finished = 1'b0;

  always #20 clk = ~clk;

  memAccessCtrl dut (.*);

  macChecker chk (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic driveRequests();
    int budget;
    budget = totalReqs - acceptCount;
    rngState = xorshift32(rngState);
    wrValid = (budget > 0) && rngState[0];
    rdValid = (budget - int'(wrValid) > 0) && rngState[1];
    wrTag = rngState[7:4];
    rdTag = rngState[11:8];
    wrId = rngState[14:12];
    rdId = rngState[17:15];
    wrLen = rngState[19:18];
    rdLen = rngState[21:20];
    rngState = xorshift32(rngState);
    wrAddr = rngState;
    rngState = xorshift32(rngState);
    rdAddr = rngState;
  endtask

  task automatic respondAck();
    if (!holdStarted && acceptCount >= totalReqs / 2) begin
      holdStarted = 1'b1;
      holdLeft = 30;   // Long stall to fill both queues
    end
    if (holdLeft > 0) begin
      holdLeft--;
    end else if (cmdReq && !cmdAck) begin
      if (ackDelay == 0) cmdAck = 1'b1;
      else ackDelay--;
    end
    if (!cmdReq && cmdAck) begin
      cmdAck = 1'b0;
      rngState = xorshift32(rngState);
      ackDelay = int'(rngState[1:0]);
    end
  endtask

  initial begin
    rngState = 32'd45;
    resetn = 1'b0;
    cmdAck = 1'b0;
    wrValid = 1'b0;
    rdValid = 1'b0;
    wrAddr = '0;
    rdAddr = '0;
    wrTag = '0;
    rdTag = '0;
    wrId = '0;
    rdId = '0;
    wrLen = '0;
    rdLen = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    while (!finished && cycles < cycleLimit) begin
      @(negedge clk);
      cycles++;
      driveRequests();
      respondAck();
      finished = (acceptCount == totalReqs) && idle && !cmdReq && !cmdAck;
    end
    chk.printSummary();
    if (!finished) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
    end
    if (finished && errorCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
macPkg.sv
issueIf.sv
reqQueue.sv
rrArbiter.sv
burstCounter.sv
cmdSequencer.sv
cmdIssue.sv
memAccessCtrl.sv
memAccessCtrl_sva.sv
macChecker.sv
tbMemAccessCtrl.sv
